// File: verilog/proxy_test_pkg.sv
package proxy_test_pkg;

    // --------------------------------------------------------------
    // Register bus
    // --------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [5:0]  reg_offs_t;

    // Region select is the upper part of the host word address
    localparam int REGION_W = $bits(reg_addr_t) - $bits(reg_offs_t);

    localparam logic [REGION_W-1:0] REGION_CTRL = REGION_W'(0);
    localparam logic [REGION_W-1:0] REGION_MEM  = REGION_W'(1);
    localparam logic [REGION_W-1:0] REGION_PLAY = REGION_W'(2);
    localparam logic [REGION_W-1:0] REGION_CAP  = REGION_W'(3);

    typedef struct packed {
        logic                wr;
        logic                rd;
        logic [REGION_W-1:0] region;
        reg_offs_t           offs;
        word_t               wdata;
    } reg_req_t;

    // Control block
    localparam reg_offs_t CTRL_ID      = 6'd0;
    localparam reg_offs_t CTRL_TRIGGER = 6'd1;
    localparam reg_offs_t CTRL_STATUS  = 6'd2;
    localparam word_t     PTST_ID      = 32'h5054_5354;

    // Memory proxy
    localparam reg_offs_t MEM_ADDR   = 6'd0;
    localparam reg_offs_t MEM_WDATA  = 6'd1;
    localparam reg_offs_t MEM_CMD    = 6'd2;
    localparam reg_offs_t MEM_STATUS = 6'd3;
    localparam reg_offs_t MEM_RDATA  = 6'd4;
    localparam int        MEM_DEPTH  = 64;

    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

    // --------------------------------------------------------------
    // Packet loop
    // --------------------------------------------------------------
    localparam reg_offs_t PLAY_LEN    = 6'd0;
    localparam reg_offs_t PLAY_SEED   = 6'd1;
    localparam reg_offs_t PLAY_START  = 6'd2;
    localparam reg_offs_t PLAY_STATUS = 6'd3;

    localparam reg_offs_t CAP_ENABLE = 6'd0;
    localparam reg_offs_t CAP_PKTS   = 6'd1;
    localparam reg_offs_t CAP_WORDS  = 6'd2;
    localparam reg_offs_t CAP_SUM    = 6'd3;
    localparam reg_offs_t CAP_CLEAR  = 6'd4;

    typedef logic [7:0] pkt_len_t;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef struct packed {
        word_t data;
        logic  last;
    } pkt_beat_t;

    typedef enum logic [1:0] {MEM_IDLE, MEM_ACCESS, MEM_DONE} mem_state_t;
    typedef enum logic {PLAY_IDLE, PLAY_SEND} play_state_t;

endpackage

// File: verilog/proxy_test_decoder.sv
`timescale 1ns/1ps

module proxy_test_decoder (
    input  logic                     clk,
    input  logic                     srst,
    input  proxy_test_pkg::reg_req_t i_req,
    input  proxy_test_pkg::word_t    i_rd_data_ctrl,
    input  proxy_test_pkg::word_t    i_rd_data_mem,
    input  proxy_test_pkg::word_t    i_rd_data_play,
    input  proxy_test_pkg::word_t    i_rd_data_cap,
    output proxy_test_pkg::reg_req_t o_req_ctrl,
    output proxy_test_pkg::reg_req_t o_req_mem,
    output proxy_test_pkg::reg_req_t o_req_play,
    output proxy_test_pkg::reg_req_t o_req_cap,
    output proxy_test_pkg::word_t    o_rd_data,
    output logic                     o_rd_valid
);
    import proxy_test_pkg::*;

    logic [REGION_W-1:0] rd_region_q;
    logic                rd_pend_q;

    // Pass the access on only to the region it addresses
    function automatic reg_req_t gate_req(input reg_req_t req, input logic [REGION_W-1:0] region);
        reg_req_t gated;
        gated    = req;
        gated.wr = req.wr && (req.region == region);
        gated.rd = req.rd && (req.region == region);
        return gated;
    endfunction

    assign o_req_ctrl = gate_req(i_req, REGION_CTRL);
    assign o_req_mem  = gate_req(i_req, REGION_MEM);
    assign o_req_play = gate_req(i_req, REGION_PLAY);
    assign o_req_cap  = gate_req(i_req, REGION_CAP);

    // Blocks answer one cycle after rd, so remember which one was asked
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_pend_q  <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            rd_pend_q  <= i_req.rd;
            o_rd_valid <= rd_pend_q;
        end
    end

    always_ff @(posedge clk) begin
        rd_region_q <= i_req.region;
        case (rd_region_q)
            REGION_CTRL: o_rd_data <= i_rd_data_ctrl;
            REGION_MEM:  o_rd_data <= i_rd_data_mem;
            REGION_PLAY: o_rd_data <= i_rd_data_play;
            default:     o_rd_data <= i_rd_data_cap;
        endcase
    end

    // Host never issues a write and a read together
    assert property (@(posedge clk) disable iff (srst) !(i_req.wr && i_req.rd));

endmodule

// File: verilog/proxy_test_reg_blk.sv
`timescale 1ns/1ps

module proxy_test_reg_blk (
    input  logic                     clk,
    input  logic                     srst,
    input  proxy_test_pkg::reg_req_t i_req,
    output proxy_test_pkg::word_t    o_rd_data
);
    import proxy_test_pkg::*;

    word_t       trigger_q;
    logic [15:0] trig_value_q;
    logic [15:0] trig_count_q;
    logic        trig_wr;

    assign trig_wr = i_req.wr && (i_req.offs == CTRL_TRIGGER);

    // Status latches each trigger write and counts them
    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_q    <= '0;
            trig_value_q <= '0;
            trig_count_q <= '0;
        end else if (trig_wr) begin
            trigger_q    <= i_req.wdata;
            trig_value_q <= i_req.wdata[15:0];
            trig_count_q <= trig_count_q + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.rd) begin
            case (i_req.offs)
                CTRL_ID:      o_rd_data <= PTST_ID;
                CTRL_TRIGGER: o_rd_data <= trigger_q;
                CTRL_STATUS:  o_rd_data <= {trig_count_q, trig_value_q};
                default:      o_rd_data <= '0;
            endcase
        end
    end

endmodule

// File: verilog/mem_proxy.sv
`timescale 1ns/1ps

module mem_proxy (
    input  logic                      clk,
    input  logic                      srst,
    input  proxy_test_pkg::reg_req_t  i_req,
    output proxy_test_pkg::word_t     o_rd_data,
    output logic                      o_ram_wr,
    output logic                      o_ram_rd,
    output proxy_test_pkg::mem_addr_t o_ram_addr,
    output proxy_test_pkg::word_t     o_ram_wdata,
    input  proxy_test_pkg::word_t     i_ram_rdata
);
    import proxy_test_pkg::*;

    mem_state_t state;
    mem_addr_t  addr_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic       op_rd_q;
    logic       cmd_go;

    // A command starts the RAM cycle at once, unless one is in flight
    assign cmd_go = i_req.wr && (i_req.offs == MEM_CMD) && (state != MEM_ACCESS)
                    && (i_req.wdata[0] || i_req.wdata[1]);

    // Write wins if both command bits are set
    assign o_ram_wr    = cmd_go && i_req.wdata[0];
    assign o_ram_rd    = cmd_go && !i_req.wdata[0];
    assign o_ram_addr  = addr_q;
    assign o_ram_wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= MEM_IDLE;
        end else if (state == MEM_ACCESS) begin
            state <= MEM_DONE;
        end else if (cmd_go) begin
            state <= MEM_ACCESS;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.wr && (i_req.offs == MEM_ADDR)) begin
            addr_q <= i_req.wdata[$bits(mem_addr_t)-1:0];
        end
        if (i_req.wr && (i_req.offs == MEM_WDATA)) begin
            wdata_q <= i_req.wdata;
        end
        if (cmd_go) begin
            op_rd_q <= o_ram_rd;
        end
        // RAM data is valid in ACCESS, so it is held from DONE onwards
        if (state == MEM_ACCESS && op_rd_q) begin
            rdata_q <= i_ram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.rd) begin
            case (i_req.offs)
                MEM_ADDR:   o_rd_data <= word_t'(addr_q);
                MEM_WDATA:  o_rd_data <= wdata_q;
                MEM_STATUS: o_rd_data <= {30'd0, state == MEM_DONE, state == MEM_ACCESS};
                MEM_RDATA:  o_rd_data <= rdata_q;
                default:    o_rd_data <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (srst) !(o_ram_wr && o_ram_rd));

endmodule

// File: verilog/mem_ram_sp.sv
`timescale 1ns/1ps

module mem_ram_sp (
    input  logic                      clk,
    input  logic                      i_wr,
    input  logic                      i_rd,
    input  proxy_test_pkg::mem_addr_t i_addr,
    input  proxy_test_pkg::word_t     i_wdata,
    output proxy_test_pkg::word_t     o_rdata
);
    import proxy_test_pkg::*;

    word_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[i_addr] <= i_wdata;
        end
        // Read data holds until the next read
        if (i_rd) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

// File: verilog/packet_playback.sv
`timescale 1ns/1ps

module packet_playback (
    input  logic                      clk,
    input  logic                      srst,
    input  proxy_test_pkg::reg_req_t  i_req,
    input  logic                      i_ready,
    output proxy_test_pkg::word_t     o_rd_data,
    output proxy_test_pkg::pkt_beat_t o_beat,
    output logic                      o_valid
);
    import proxy_test_pkg::*;

    play_state_t state;
    pkt_len_t    len_q;
    word_t       seed_q;
    pkt_len_t    eng_len_q;
    pkt_len_t    idx_q;
    word_t       data_q;
    logic        start;
    logic        accept;
    logic        last_beat;

    // Start is dropped while a packet is still going out
    assign start     = i_req.wr && (i_req.offs == PLAY_START) && (state == PLAY_IDLE);
    assign accept    = o_valid && i_ready;
    assign last_beat = (idx_q == eng_len_q - 8'd1);

    assign o_valid     = (state == PLAY_SEND);
    assign o_beat.data = data_q;
    assign o_beat.last = last_beat;

    always_ff @(posedge clk) begin
        if (srst) begin
            state  <= PLAY_IDLE;
            len_q  <= '0;
            seed_q <= '0;
        end else begin
            if (i_req.wr && (i_req.offs == PLAY_LEN)) begin
                len_q <= i_req.wdata[$bits(pkt_len_t)-1:0];
            end
            if (i_req.wr && (i_req.offs == PLAY_SEED)) begin
                seed_q <= i_req.wdata;
            end
            if (start) begin
                state <= PLAY_SEND;
            end else if (accept && last_beat) begin
                state <= PLAY_IDLE;
            end
        end
    end

    // Word i of the packet is seed + i
    always_ff @(posedge clk) begin
        if (start) begin
            eng_len_q <= len_q;
            data_q    <= seed_q;
            idx_q     <= '0;
        end else if (accept) begin
            data_q <= data_q + 32'd1;
            idx_q  <= idx_q + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.rd) begin
            case (i_req.offs)
                PLAY_LEN:    o_rd_data <= word_t'(len_q);
                PLAY_SEED:   o_rd_data <= seed_q;
                PLAY_STATUS: o_rd_data <= {31'd0, state == PLAY_SEND};
                default:     o_rd_data <= '0;
            endcase
        end
    end

endmodule

// File: verilog/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
    input  logic                      clk,
    input  logic                      srst,
    input  proxy_test_pkg::pkt_beat_t i_beat,
    input  logic                      i_valid,
    input  logic                      i_ready,
    output logic                      o_ready,
    output proxy_test_pkg::pkt_beat_t o_beat,
    output logic                      o_valid
);
    import proxy_test_pkg::*;

    pkt_beat_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  push;
    logic                  pop;

    assign o_ready = (count != FIFO_DEPTH);
    assign o_valid = (count != '0);
    assign o_beat  = mem[rd_ptr];

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_beat;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // No push into a full FIFO and no pop from an empty one
    assert property (@(posedge clk) disable iff (srst)
        (count == FIFO_DEPTH) && !pop |=> (count == FIFO_DEPTH));
    assert property (@(posedge clk) disable iff (srst)
        (count == '0) && !push |=> (count == '0));

endmodule

// File: verilog/packet_capture.sv
`timescale 1ns/1ps

module packet_capture (
    input  logic                      clk,
    input  logic                      srst,
    input  proxy_test_pkg::reg_req_t  i_req,
    input  proxy_test_pkg::pkt_beat_t i_beat,
    input  logic                      i_valid,
    output logic                      o_ready,
    output proxy_test_pkg::word_t     o_rd_data
);
    import proxy_test_pkg::*;

    logic     en_q;
    word_t    pkts_q;
    word_t    words_q;
    word_t    sum_q;
    word_t    acc_sum_q;
    pkt_len_t acc_len_q;
    logic     accept;
    logic     clear;

    assign o_ready = en_q;
    assign accept  = i_valid && en_q;
    assign clear   = i_req.wr && (i_req.offs == CAP_CLEAR);

    always_ff @(posedge clk) begin
        if (srst) begin
            en_q      <= 1'b0;
            pkts_q    <= '0;
            words_q   <= '0;
            sum_q     <= '0;
            acc_sum_q <= '0;
            acc_len_q <= '0;
        end else begin
            if (i_req.wr && (i_req.offs == CAP_ENABLE)) begin
                en_q <= i_req.wdata[0];
            end
            // Running totals of the current packet, committed on last
            if (accept && i_beat.last) begin
                pkts_q    <= pkts_q + 32'd1;
                words_q   <= words_q + word_t'(acc_len_q) + 32'd1;
                sum_q     <= acc_sum_q + i_beat.data;
                acc_sum_q <= '0;
                acc_len_q <= '0;
            end else if (accept) begin
                acc_sum_q <= acc_sum_q + i_beat.data;
                acc_len_q <= acc_len_q + 8'd1;
            end
            if (clear) begin
                pkts_q  <= '0;
                words_q <= '0;
                sum_q   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.rd) begin
            case (i_req.offs)
                CAP_ENABLE: o_rd_data <= {31'd0, en_q};
                CAP_PKTS:   o_rd_data <= pkts_q;
                CAP_WORDS:  o_rd_data <= words_q;
                CAP_SUM:    o_rd_data <= sum_q;
                default:    o_rd_data <= '0;
            endcase
        end
    end

endmodule

// File: verilog/proxy_test.sv
`timescale 1ns/1ps

module proxy_test (
    input  logic                     clk,
    input  logic                     srst,
    input  proxy_test_pkg::reg_req_t i_req,
    output proxy_test_pkg::word_t    o_rd_data,
    output logic                     o_rd_valid
);
    import proxy_test_pkg::*;

    reg_req_t  req_ctrl;
    reg_req_t  req_mem;
    reg_req_t  req_play;
    reg_req_t  req_cap;
    word_t     rd_data_ctrl;
    word_t     rd_data_mem;
    word_t     rd_data_play;
    word_t     rd_data_cap;

    logic      ram_wr;
    logic      ram_rd;
    mem_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;

    pkt_beat_t play_beat;
    logic      play_valid;
    logic      fifo_ready;
    pkt_beat_t fifo_beat;
    logic      fifo_valid;
    logic      cap_ready;

    // ------------------------------------------------------------------
    // Register decode and control block
    // ------------------------------------------------------------------
    proxy_test_decoder i_decoder (
        .clk,
        .srst,
        .i_req          ( i_req ),
        .i_rd_data_ctrl ( rd_data_ctrl ),
        .i_rd_data_mem  ( rd_data_mem ),
        .i_rd_data_play ( rd_data_play ),
        .i_rd_data_cap  ( rd_data_cap ),
        .o_req_ctrl     ( req_ctrl ),
        .o_req_mem      ( req_mem ),
        .o_req_play     ( req_play ),
        .o_req_cap      ( req_cap ),
        .o_rd_data      ( o_rd_data ),
        .o_rd_valid     ( o_rd_valid )
    );

    proxy_test_reg_blk i_reg_blk (
        .clk,
        .srst,
        .i_req     ( req_ctrl ),
        .o_rd_data ( rd_data_ctrl )
    );

    // ------------------------------------------------------------------
    // Memory proxy
    // ------------------------------------------------------------------
    mem_proxy i_mem_proxy (
        .clk,
        .srst,
        .i_req       ( req_mem ),
        .o_rd_data   ( rd_data_mem ),
        .o_ram_wr    ( ram_wr ),
        .o_ram_rd    ( ram_rd ),
        .o_ram_addr  ( ram_addr ),
        .o_ram_wdata ( ram_wdata ),
        .i_ram_rdata ( ram_rdata )
    );

    mem_ram_sp i_mem_ram (
        .clk,
        .i_wr    ( ram_wr ),
        .i_rd    ( ram_rd ),
        .i_addr  ( ram_addr ),
        .i_wdata ( ram_wdata ),
        .o_rdata ( ram_rdata )
    );

    // ------------------------------------------------------------------
    // Packet loop, playback to FIFO to capture
    // ------------------------------------------------------------------
    packet_playback i_packet_playback (
        .clk,
        .srst,
        .i_req     ( req_play ),
        .i_ready   ( fifo_ready ),
        .o_rd_data ( rd_data_play ),
        .o_beat    ( play_beat ),
        .o_valid   ( play_valid )
    );

    packet_fifo i_packet_fifo (
        .clk,
        .srst,
        .i_beat  ( play_beat ),
        .i_valid ( play_valid ),
        .i_ready ( cap_ready ),
        .o_ready ( fifo_ready ),
        .o_beat  ( fifo_beat ),
        .o_valid ( fifo_valid )
    );

    packet_capture i_packet_capture (
        .clk,
        .srst,
        .i_req     ( req_cap ),
        .i_beat    ( fifo_beat ),
        .i_valid   ( fifo_valid ),
        .o_ready   ( cap_ready ),
        .o_rd_data ( rd_data_cap )
    );

endmodule

// File: bench/proxy_test_tb.sv
`timescale 1ns/1ps

module proxy_test_tb;
    import proxy_test_pkg::*;

    localparam int CYCLES_PER_LINE = 200;
    localparam int POLL_TRIES      = 64;

    logic     clk;
    logic     srst;
    reg_req_t i_req;
    word_t    o_rd_data;
    logic     o_rd_valid;

    int       cycle_count = 0;
    int       cycle_limit = 0;

    proxy_test dut (
        .clk        ( clk ),
        .srst       ( srst ),
        .i_req      ( i_req ),
        .o_rd_data  ( o_rd_data ),
        .o_rd_valid ( o_rd_valid )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Run control and checking
    // ------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // Whole run is bounded by the trace length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
        end
    end

    // ------------------------------------------------------------------
    // Host register bus
    // ------------------------------------------------------------------
    function automatic reg_req_t make_req(input logic wr, input logic rd,
                                          input reg_addr_t addr, input word_t wdata);
        reg_req_t req;
        req.wr     = wr;
        req.rd     = rd;
        req.region = addr[7:6];
        req.offs   = addr[5:0];
        req.wdata  = wdata;
        return req;
    endfunction

    task automatic bus_write(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        i_req <= make_req(1'b1, 1'b0, addr, data);
        @(posedge clk);
        i_req <= '0;
    endtask

    // Data comes back with o_rd_valid exactly two cycles after the strobe
    task automatic bus_read(input reg_addr_t addr, output word_t data);
        @(posedge clk);
        i_req <= make_req(1'b0, 1'b1, addr, '0);
        @(posedge clk);
        i_req <= '0;
        @(negedge clk);
        check_value($sformatf("o_rd_valid one cycle after read of 0x%h", addr),
                    word_t'(o_rd_valid), 32'd0);
        @(negedge clk);
        check_value($sformatf("o_rd_valid two cycles after read of 0x%h", addr),
                    word_t'(o_rd_valid), 32'd1);
        data = o_rd_data;
    endtask

    task automatic poll_read(input reg_addr_t addr, input word_t expected);
        word_t got;
        logic  matched;
        int    tries;
        matched = 1'b0;
        tries   = 0;
        while (!matched && tries < POLL_TRIES) begin
            bus_read(addr, got);
            matched = (got === expected);
            tries++;
        end
        if (!matched) begin
            fail_run($sformatf("Address 0x%h never read 0x%h in %0d reads, last was 0x%h",
                               addr, expected, POLL_TRIES, got));
        end
    endtask

    // ------------------------------------------------------------------
    // Trace playback
    // ------------------------------------------------------------------
    initial begin
        logic [8*256-1:0] line_buf;
        logic [7:0]       op;
        reg_addr_t        addr;
        word_t            value;
        word_t            got;
        int               fd;
        int               code;
        int               n_lines;
        i_req = '0;
        srst  = 1'b1;

        // First pass only counts lines for the timeout
        n_lines = 0;
        fd = $fopen("bench/proxy_test_trace.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the trace file bench/proxy_test_trace.txt");
        end
        while ($fgets(line_buf, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        cycle_limit = 8 + CYCLES_PER_LINE * n_lines;

        repeat (8) @(posedge clk);
        srst <= 1'b0;

        fd = $fopen("bench/proxy_test_trace.txt", "r");
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                code = $fgets(line_buf, fd);
            end else if (op == "D") begin
                code = $fscanf(fd, " %h", value);
                repeat (value) @(posedge clk);
            end else begin
                code = $fscanf(fd, " %h %h", addr, value);
                case (op)
                    "W": bus_write(addr, value);
                    "P": poll_read(addr, value);
                    "R": begin
                        bus_read(addr, got);
                        check_value($sformatf("o_rd_data at 0x%h", addr), got, value);
                    end
                    default: fail_run($sformatf("Unknown trace operation %c", op));
                endcase
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: bench/proxy_test_trace.txt
# op addr value, all hex: W write, R read and compare, P poll until equal
# D has one field, the number of idle cycles
R 00 50545354
W 01 0000a5a5
W 01 00001234
R 01 00001234
R 02 00021234
W 40 00000003
W 41 11112222
W 42 00000001
W 40 00000011
W 41 deadbeef
W 42 00000001
W 40 0000002a
W 41 0badcafe
W 42 00000001
W 40 00000011
W 42 00000002
P 43 00000002
R 44 deadbeef
W 40 00000003
W 42 00000002
R 44 11112222
W 40 0000002a
W 42 00000002
R 44 0badcafe
W c0 00000001
W 80 00000005
W 81 00000064
W 82 00000001
P 83 00000000
P c1 00000001
R c2 00000005
R c3 000001fe
W c0 00000000
W 80 00000014
W 81 000003e8
W 82 00000001
D 28
R 83 00000001
W c0 00000001
P 83 00000000
P c2 00000019
R c1 00000002
R c3 00004ede
W c4 00000001
R c1 00000000
R c2 00000000
R c3 00000000
R 3f 00000000
R 7f 00000000
R bf 00000000
R ff 00000000

// File: proxy_test.f
verilog/proxy_test_pkg.sv
verilog/proxy_test_decoder.sv
verilog/proxy_test_reg_blk.sv
verilog/mem_proxy.sv
verilog/mem_ram_sp.sv
verilog/packet_playback.sv
verilog/packet_fifo.sv
verilog/packet_capture.sv
verilog/proxy_test.sv
bench/proxy_test_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f proxy_test.f --top-module proxy_test_tb

sim_out=$(./obj_dir/Vproxy_test_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^Everything OK$"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
